/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= mcUnitTb
FILELIST  ?= mcUnit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := SOME TESTS FAILED
PASS_MSG  := ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hw/divEngine.sv */
module divEngine (
    input  logic                         CLK,
    input  logic                         Reset,
    input  logic                         Launch,
    input  mcPkg::mcOpT                  Op,
    input  logic [mcPkg::DataWidth-1:0]  Dividend,
    input  logic [mcPkg::DataWidth-1:0]  Divisor,
    output logic [mcPkg::DataWidth-1:0]  Quotient,
    output logic [mcPkg::DataWidth-1:0]  Remainder,
    output logic                         DivFinish
);
    import mcPkg::*;

    logic                  start;
    logic [CountWidth-1:0] countReg;
    logic                  running;
    logic [DataWidth-1:0]  quoReg;
    logic [DataWidth-1:0]  remReg;
    logic [DataWidth-1:0]  divisorReg;
    logic [DataWidth:0]    shifted;
    logic [DataWidth:0]    diff;
    logic                  noBorrow;

    assign start   = Launch && (Op == OpUdiv);
    assign running = (countReg != '0);

    ///////////////////////////////////////////////////////////////////////
    // Iteration control
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            countReg  <= '0;
            DivFinish <= 1'b0;
        end else begin
            DivFinish <= 1'b0;
            if (start) begin
                countReg <= CountWidth'(IterCount);
            end else if (running) begin
                countReg <= countReg - 1'b1;
                if (countReg == CountWidth'(1)) begin
                    DivFinish <= 1'b1;
                end
            end
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Restoring datapath
    ///////////////////////////////////////////////////////////////////////

    // Next dividend bit enters the partial remainder from the right
    assign shifted = {remReg, quoReg[DataWidth-1]};

    // Subtract as add of the inverted divisor with carry-in set
    assign {noBorrow, diff} = {1'b0, shifted} + {1'b0, ~{1'b0, divisorReg}} + 1'b1;

    always_ff @(posedge CLK) begin
        if (start) begin
            quoReg     <= Dividend;
            remReg     <= '0;
            divisorReg <= Divisor;
        end else if (running) begin
            if (noBorrow) begin
                remReg <= diff[DataWidth-1:0];
                quoReg <= {quoReg[DataWidth-2:0], 1'b1};
            end else begin
                // Restore by keeping the shifted remainder
                remReg <= shifted[DataWidth-1:0];
                quoReg <= {quoReg[DataWidth-2:0], 1'b0};
            end
        end
    end

    assign Quotient  = quoReg;
    assign Remainder = remReg;

endmodule

/* hw/mcPkg.sv */
package mcPkg;

    ///////////////////////////////////////////////////////////////////////
    // Widths and iteration count
    ///////////////////////////////////////////////////////////////////////

    localparam int DataWidth = 32;

    // One engine step per operand bit
    localparam int IterCount = DataWidth;

    // Wide enough to hold IterCount itself
    localparam int CountWidth = $clog2(IterCount) + 1;

    // Register file index width
    localparam int TagWidth = 4;

    ///////////////////////////////////////////////////////////////////////
    // Types
    ///////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        OpMul   = 2'd0,
        OpMla   = 2'd1,
        OpUmull = 2'd2,
        OpUdiv  = 2'd3
    } mcOpT;

    typedef enum logic [1:0] {
        StIdle   = 2'd0,
        StRun    = 2'd1,
        StFinish = 2'd2
    } mergeStateT;

endpackage

/* hw/mcUnit.sv */
module mcUnit (
    input  logic                         CLK,
    input  logic                         Reset,
    input  logic                         Start,
    input  mcPkg::mcOpT                  Op,
    input  logic [mcPkg::DataWidth-1:0]  Operand1,
    input  logic [mcPkg::DataWidth-1:0]  Operand2,
    input  logic [mcPkg::DataWidth-1:0]  Operand3,
    input  logic [mcPkg::TagWidth-1:0]   DestLow,
    input  logic [mcPkg::TagWidth-1:0]   DestHigh,
    output logic [mcPkg::DataWidth-1:0]  ResultLow,
    output logic [mcPkg::DataWidth-1:0]  ResultHigh,
    output logic [mcPkg::TagWidth-1:0]   ResultDestLow,
    output logic [mcPkg::TagWidth-1:0]   ResultDestHigh,
    output logic                         WriteHigh,
    output logic                         Busy,
    output logic                         Done
);
    import mcPkg::*;

    logic                   launch;
    logic                   mulFinish;
    logic                   divFinish;
    logic [2*DataWidth-1:0] product;
    logic [DataWidth-1:0]   quotient;
    logic [DataWidth-1:0]   remainder;

    // Both engines see every launch and pick their own opcodes
    mulEngine u_mulEngine (
        .CLK(CLK), .Reset(Reset), .Launch(launch), .Op(Op),
        .Multiplicand(Operand1), .Multiplier(Operand2),
        .Product(product), .MulFinish(mulFinish)
    );

    divEngine u_divEngine (
        .CLK(CLK), .Reset(Reset), .Launch(launch), .Op(Op),
        .Dividend(Operand1), .Divisor(Operand2),
        .Quotient(quotient), .Remainder(remainder), .DivFinish(divFinish)
    );

    resultMerge u_resultMerge (
        .CLK(CLK), .Reset(Reset), .Start(Start), .Op(Op),
        .Operand3(Operand3), .DestLow(DestLow), .DestHigh(DestHigh),
        .MulFinish(mulFinish), .Product(product),
        .DivFinish(divFinish), .Quotient(quotient), .Remainder(remainder),
        .Launch(launch),
        .ResultLow(ResultLow), .ResultHigh(ResultHigh),
        .ResultDestLow(ResultDestLow), .ResultDestHigh(ResultDestHigh),
        .WriteHigh(WriteHigh), .Busy(Busy), .Done(Done)
    );

endmodule

/* hw/mulEngine.sv */
module mulEngine (
    input  logic                           CLK,
    input  logic                           Reset,
    input  logic                           Launch,
    input  mcPkg::mcOpT                    Op,
    input  logic [mcPkg::DataWidth-1:0]    Multiplicand,
    input  logic [mcPkg::DataWidth-1:0]    Multiplier,
    output logic [2*mcPkg::DataWidth-1:0]  Product,
    output logic                           MulFinish
);
    import mcPkg::*;

    logic                  start;
    logic [CountWidth-1:0] countReg;
    logic                  running;
    logic [2*DataWidth-1:0] accReg;
    logic [DataWidth-1:0]  mcandReg;
    logic [DataWidth-1:0]  addend;
    logic [DataWidth:0]    sum;

    // Every opcode except the divide belongs to this engine
    assign start   = Launch && (Op != OpUdiv);
    assign running = (countReg != '0);

    ///////////////////////////////////////////////////////////////////////
    // Iteration control
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            countReg  <= '0;
            MulFinish <= 1'b0;
        end else begin
            MulFinish <= 1'b0;
            if (start) begin
                countReg <= CountWidth'(IterCount);
            end else if (running) begin
                countReg <= countReg - 1'b1;
                // Last step happens on this edge
                if (countReg == CountWidth'(1)) begin
                    MulFinish <= 1'b1;
                end
            end
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Shift-add datapath
    ///////////////////////////////////////////////////////////////////////

    // Add the multiplicand only when the current multiplier bit is set
    assign addend = accReg[0] ? mcandReg : '0;
    assign sum    = {1'b0, accReg[2*DataWidth-1 -: DataWidth]} + {1'b0, addend};

    always_ff @(posedge CLK) begin
        if (start) begin
            accReg   <= {{DataWidth{1'b0}}, Multiplier};
            mcandReg <= Multiplicand;
        end else if (running) begin
            // Carry, sum and the remaining multiplier bits move right together
            accReg <= {sum, accReg[DataWidth-1:1]};
        end
    end

    assign Product = accReg;

endmodule

/* hw/resultMerge.sv */
module resultMerge (
    input  logic                           CLK,
    input  logic                           Reset,
    input  logic                           Start,
    input  mcPkg::mcOpT                    Op,
    input  logic [mcPkg::DataWidth-1:0]    Operand3,
    input  logic [mcPkg::TagWidth-1:0]     DestLow,
    input  logic [mcPkg::TagWidth-1:0]     DestHigh,
    input  logic                           MulFinish,
    input  logic [2*mcPkg::DataWidth-1:0]  Product,
    input  logic                           DivFinish,
    input  logic [mcPkg::DataWidth-1:0]    Quotient,
    input  logic [mcPkg::DataWidth-1:0]    Remainder,
    output logic                           Launch,
    output logic [mcPkg::DataWidth-1:0]    ResultLow,
    output logic [mcPkg::DataWidth-1:0]    ResultHigh,
    output logic [mcPkg::TagWidth-1:0]     ResultDestLow,
    output logic [mcPkg::TagWidth-1:0]     ResultDestHigh,
    output logic                           WriteHigh,
    output logic                           Busy,
    output logic                           Done
);
    import mcPkg::*;

    mergeStateT           state;
    mergeStateT           nextState;
    mcOpT                 opReg;
    logic [TagWidth-1:0]  destLowReg;
    logic [TagWidth-1:0]  destHighReg;
    logic [DataWidth-1:0] accumReg;
    logic                 finish;
    logic [DataWidth-1:0] lowSel;
    logic [DataWidth-1:0] highSel;

    ///////////////////////////////////////////////////////////////////////
    // Acceptance and busy FSM
    ///////////////////////////////////////////////////////////////////////

    assign finish = MulFinish | DivFinish;
    assign Busy   = (state == StRun);
    assign Done   = (state == StFinish);

    // A Start in the Done cycle is accepted as well
    assign Launch = Start && !Busy;

    always_comb begin
        nextState = state;
        case (state)
            StIdle:   if (Launch) nextState = StRun;
            StRun:    if (finish) nextState = StFinish;
            StFinish: nextState = Launch ? StRun : StIdle;
            default:  nextState = StIdle;
        endcase
    end

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            state <= StIdle;
        end else begin
            state <= nextState;
        end
    end

    // Opcode, tags and accumulate value held for the whole run
    always_ff @(posedge CLK) begin
        if (Launch) begin
            opReg       <= Op;
            destLowReg  <= DestLow;
            destHighReg <= DestHigh;
            accumReg    <= (Op == OpMla) ? Operand3 : '0;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Result combining
    ///////////////////////////////////////////////////////////////////////

    assign lowSel  = MulFinish ? Product[DataWidth-1:0] : Quotient;
    assign highSel = MulFinish ? Product[2*DataWidth-1 -: DataWidth] : Remainder;

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            ResultLow      <= '0;
            ResultHigh     <= '0;
            ResultDestLow  <= '0;
            ResultDestHigh <= '0;
            WriteHigh      <= 1'b0;
        end else if (finish) begin
            // Accumulate is zero for everything but MLA
            ResultLow      <= lowSel + accumReg;
            ResultHigh     <= highSel;
            ResultDestLow  <= destLowReg;
            ResultDestHigh <= destHighReg;
            WriteHigh      <= (opReg == OpUmull) || (opReg == OpUdiv);
        end
    end

endmodule

/* mcUnit.f */
hw/mcPkg.sv
hw/mulEngine.sv
hw/divEngine.sv
hw/resultMerge.sv
hw/mcUnit.sv
tb/mcUnitChecker.sv
tb/mcUnitTb.sv

/* tb/mcUnitChecker.sv */
module mcUnitChecker (
    input  logic                         CLK,
    input  logic                         Reset,
    input  logic                         Armed,
    input  logic                         ResetCheck,
    input  int                           TestIndex,
    input  mcPkg::mcOpT                  ExpOp,
    input  logic [mcPkg::DataWidth-1:0]  ExpLow,
    input  logic [mcPkg::DataWidth-1:0]  ExpHigh,
    input  logic                         ExpWriteHigh,
    input  logic [mcPkg::TagWidth-1:0]   ExpDestLow,
    input  logic [mcPkg::TagWidth-1:0]   ExpDestHigh,
    input  logic [mcPkg::DataWidth-1:0]  ResultLow,
    input  logic [mcPkg::DataWidth-1:0]  ResultHigh,
    input  logic [mcPkg::TagWidth-1:0]   ResultDestLow,
    input  logic [mcPkg::TagWidth-1:0]   ResultDestHigh,
    input  logic                         WriteHigh,
    input  logic                         Busy,
    input  logic                         Done,
    output logic                         Waiting,
    output int                           PassCount,
    output int                           FailCount
);
    timeunit 1ns;
    timeprecision 1ps;
    import mcPkg::*;

    int currentTest = 0;
    int edgeCount = 0;
    int rowErrors = 0;
    int passes = 0;
    int fails = 0;
    bit busyFlagged = 1'b0;

    assign PassCount = passes;
    assign FailCount = fails;

    task automatic compareField(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
            rowErrors++;
        end
    endtask

    task automatic finishTest(input string label);
        if (rowErrors == 0) begin
            $display("test %0d %s: passed", currentTest, label);
            passes++;
        end else begin
            $display("test %0d %s: failed with %0d errors", currentTest, label, rowErrors);
            fails++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Sampling on every rising edge
    //////////////////////////////////////////////////////////////////////

    always @(posedge CLK) begin
        if (Reset) begin
            Waiting <= 1'b0;
        end else begin
            if (ResetCheck) begin
                currentTest = TestIndex;
                rowErrors = 0;
                compareField("Busy", 1'b0, Busy);
                compareField("Done", 1'b0, Done);
                compareField("ResultLow", '0, ResultLow);
                compareField("ResultHigh", '0, ResultHigh);
                compareField("ResultDestLow", '0, ResultDestLow);
                compareField("ResultDestHigh", '0, ResultDestHigh);
                compareField("WriteHigh", 1'b0, WriteHigh);
                finishTest("reset");
            end
            if (Armed) begin
                // This edge samples Start
                Waiting <= 1'b1;
                currentTest = TestIndex;
                edgeCount = 0;
                rowErrors = 0;
                busyFlagged = 1'b0;
            end else if (Waiting) begin
                if (Done) begin
                    compareField("ResultLow", ExpLow, ResultLow);
                    compareField("ResultHigh", ExpHigh, ResultHigh);
                    compareField("WriteHigh", ExpWriteHigh, WriteHigh);
                    compareField("ResultDestLow", ExpDestLow, ResultDestLow);
                    compareField("ResultDestHigh", ExpDestHigh, ResultDestHigh);
                    compareField("Busy", 1'b0, Busy);
                    // One launch edge plus one edge per iteration
                    compareField("latency", IterCount + 1, edgeCount);
                    finishTest(ExpOp.name());
                    Waiting <= 1'b0;
                end else begin
                    if (!Busy && !busyFlagged) begin
                        $display("test %0d: Busy went low before Done", currentTest);
                        rowErrors++;
                        busyFlagged = 1'b1;
                    end
                    edgeCount++;
                    if (edgeCount > 40) begin
                        $display("test %0d: no Done within 40 cycles of Start", currentTest);
                        fails++;
                        Waiting <= 1'b0;
                    end
                end
            end else if (Done) begin
                $display("Done seen at %0d ns with no operation outstanding", $time);
                fails++;
            end
        end
    end

endmodule

/* tb/mcUnitTb.sv */
module mcUnitTb;
    timeunit 1ns;
    timeprecision 1ps;
    import mcPkg::*;

    typedef struct packed {
        mcOpT                 op;
        logic [DataWidth-1:0] a;
        logic [DataWidth-1:0] b;
        logic [DataWidth-1:0] c;
        logic [TagWidth-1:0]  dl;
        logic [TagWidth-1:0]  dh;
        logic [DataWidth-1:0] expLow;
        logic [DataWidth-1:0] expHigh;
        logic                 expWh;
        logic                 extra;
    } rowT;

    logic CLK, Reset, Start;
    mcOpT Op, ExpOp;
    logic [DataWidth-1:0] Operand1, Operand2, Operand3;
    logic [TagWidth-1:0] DestLow, DestHigh, ExpDestLow, ExpDestHigh;
    logic [DataWidth-1:0] ResultLow, ResultHigh, ExpLow, ExpHigh;
    logic [TagWidth-1:0] ResultDestLow, ResultDestHigh;
    logic WriteHigh, Busy, Done, ExpWriteHigh;
    logic Armed, ResetCheck, Waiting;
    int TestIndex, PassCount, FailCount;

    rowT rows[$];
    logic [31:0] lfsrState = 32'h4c28da1e;
    int cycleCount = 0;
    int cycleLimit = 0;

    mcUnit u_mcUnit (
        .CLK(CLK), .Reset(Reset), .Start(Start), .Op(Op),
        .Operand1(Operand1), .Operand2(Operand2), .Operand3(Operand3),
        .DestLow(DestLow), .DestHigh(DestHigh),
        .ResultLow(ResultLow), .ResultHigh(ResultHigh),
        .ResultDestLow(ResultDestLow), .ResultDestHigh(ResultDestHigh),
        .WriteHigh(WriteHigh), .Busy(Busy), .Done(Done)
    );

    mcUnitChecker u_mcUnitChecker (
        .CLK(CLK), .Reset(Reset), .Armed(Armed), .ResetCheck(ResetCheck),
        .TestIndex(TestIndex), .ExpOp(ExpOp), .ExpLow(ExpLow), .ExpHigh(ExpHigh),
        .ExpWriteHigh(ExpWriteHigh), .ExpDestLow(ExpDestLow), .ExpDestHigh(ExpDestHigh),
        .ResultLow(ResultLow), .ResultHigh(ResultHigh),
        .ResultDestLow(ResultDestLow), .ResultDestHigh(ResultDestHigh),
        .WriteHigh(WriteHigh), .Busy(Busy), .Done(Done),
        .Waiting(Waiting), .PassCount(PassCount), .FailCount(FailCount)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    //////////////////////////////////////////////////////////////////////
    // Random operands and reference arithmetic
    //////////////////////////////////////////////////////////////////////

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic takeBits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
    endtask

    function automatic void predict(input mcOpT op, input logic [31:0] a, b, c,
                                    output logic [31:0] low, high, output logic wh);
        logic [63:0] prod;
        prod = {32'd0, a} * {32'd0, b};
        low  = prod[31:0];
        high = prod[63:32];
        case (op)
            OpMul: begin
                wh = 1'b0;
            end
            OpMla: begin
                low = prod[31:0] + c;
                wh  = 1'b0;
            end
            OpUmull: begin
                wh = 1'b1;
            end
            OpUdiv: begin
                low  = (b == 0) ? 32'hffffffff : a / b;
                high = (b == 0) ? a : a % b;
                wh   = 1'b1;
            end
        endcase
    endfunction

    task automatic addRow(input mcOpT op, input logic [31:0] a, b, c,
                          input logic [3:0] dl, dh, input logic [31:0] expLow, expHigh,
                          input logic expWh, extra);
        rows.push_back({op, a, b, c, dl, dh, expLow, expHigh, expWh, extra});
    endtask

    task automatic addRandomRows(input int count);
        logic [31:0] opBits, a, b, c, tags, low, high;
        logic wh;
        mcOpT op;
        for (int i = 0; i < count; i++) begin
            takeBits(2, opBits);
            op = mcOpT'(opBits[1:0]);
            takeBits(32, a);
            // Narrow divisors give quotients wider than one bit
            takeBits((op == OpUdiv) ? 12 : 32, b);
            takeBits(32, c);
            takeBits(8, tags);
            predict(op, a, b, c, low, high, wh);
            rows.push_back({op, a, b, c, tags[7:4], tags[3:0], low, high, wh, 1'b0});
        end
    endtask

    task automatic runRow(input int index);
        rowT r;
        r = rows[index];
        @(posedge CLK);
        Start <= 1'b1;
        Op <= r.op;
        Operand1 <= r.a;
        Operand2 <= r.b;
        Operand3 <= r.c;
        DestLow <= r.dl;
        DestHigh <= r.dh;
        ExpOp <= r.op;
        ExpLow <= r.expLow;
        ExpHigh <= r.expHigh;
        ExpWriteHigh <= r.expWh;
        ExpDestLow <= r.dl;
        ExpDestHigh <= r.dh;
        TestIndex <= index + 1;
        Armed <= 1'b1;
        @(posedge CLK);
        Start <= 1'b0;
        Armed <= 1'b0;
        if (r.extra) begin
            // Competing request in the middle of the run
            repeat (4) @(posedge CLK);
            Start <= 1'b1;
            Op <= (r.op == OpUdiv) ? OpMla : OpUdiv;
            Operand1 <= ~r.a;
            Operand2 <= r.b + 1;
            Operand3 <= ~r.c;
            DestLow <= ~r.dl;
            DestHigh <= ~r.dh;
            @(posedge CLK);
            Start <= 1'b0;
        end
        do begin
            @(posedge CLK);
        end while (Waiting);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus table and main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        Reset = 1'b1;
        Start = 1'b0;
        Op = OpMul;
        Operand1 = '0;
        Operand2 = '0;
        Operand3 = '0;
        DestLow = '0;
        DestHigh = '0;
        Armed = 1'b0;
        ResetCheck = 1'b0;
        TestIndex = 0;
        ExpOp = OpMul;
        ExpLow = '0;
        ExpHigh = '0;
        ExpWriteHigh = 1'b0;
        ExpDestLow = '0;
        ExpDestHigh = '0;

        // op, a, b, c, tags, low, high, WriteHigh, second Start
        addRow(OpMul, 'h7, 'h6, 'h11111111, 4'd1, 4'd2, 'h2a, 'h0, 1'b0, 1'b0);
        addRow(OpMul, 'hffffffff, 'hffffffff, 'h0, 4'd3, 4'd4, 'h1, 'hfffffffe, 1'b0, 1'b0);
        addRow(OpMul, 'h0, 'h12345678, 'h5, 4'd5, 4'd6, 'h0, 'h0, 1'b0, 1'b0);
        addRow(OpUmull, 'h10000, 'h10000, 'h0, 4'd7, 4'd8, 'h0, 'h1, 1'b1, 1'b0);
        addRow(OpUmull, 'hffffffff, 'hffffffff, 'hdeadbeef, 4'd9, 4'd10, 'h1, 'hfffffffe,
               1'b1, 1'b0);
        addRow(OpUmull, 'h12345678, 'h0, 'h0, 4'd11, 4'd12, 'h0, 'h0, 1'b1, 1'b0);
        // Accumulate wraps modulo 2^32
        addRow(OpMla, 'h3, 'h5, 'ha, 4'd13, 4'd14, 'h19, 'h0, 1'b0, 1'b0);
        addRow(OpMla, 'hffffffff, 'h2, 'h3, 4'd15, 4'd0, 'h1, 'h1, 1'b0, 1'b0);
        addRow(OpMla, 'h80000000, 'h2, 'h80000000, 4'd2, 4'd9, 'h80000000, 'h1, 1'b0, 1'b0);
        addRow(OpUdiv, 'd100, 'd7, 'h0, 4'd4, 4'd5, 'd14, 'd2, 1'b1, 1'b0);
        addRow(OpUdiv, 'd5, 'd9, 'h0, 4'd6, 4'd7, 'd0, 'd5, 1'b1, 1'b0);
        addRow(OpUdiv, 'hdeadbeef, 'h1, 'h0, 4'd8, 4'd1, 'hdeadbeef, 'h0, 1'b1, 1'b0);
        addRow(OpUdiv, 'h12345678, 'h0, 'h0, 4'd3, 4'd12, 'hffffffff, 'h12345678, 1'b1, 1'b0);
        addRow(OpUdiv, 'hffffffff, 'hffffffff, 'h0, 4'd10, 4'd11, 'h1, 'h0, 1'b1, 1'b0);
        addRow(OpMul, 'h12345678, 'h10, 'h0, 4'd14, 4'd15, 'h23456780, 'h1, 1'b0, 1'b1);
        addRow(OpUdiv, 'd1000, 'd10, 'h0, 4'd1, 4'd6, 'd100, 'd0, 1'b1, 1'b1);
        addRandomRows(12);
        cycleLimit = rows.size() * 40 + 100;

        repeat (16) @(posedge CLK);
        Reset <= 1'b0;
        @(posedge CLK);
        ResetCheck <= 1'b1;
        @(posedge CLK);
        ResetCheck <= 1'b0;
        foreach (rows[i]) begin
            runRow(i);
        end
        repeat (4) @(posedge CLK);

        $display("Summary: %0d tests, %0d passed, %0d failed",
                 rows.size() + 1, PassCount, FailCount);
        if (FailCount == 0 && PassCount == rows.size() + 1) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    always @(posedge CLK) begin
        cycleCount++;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            $display("Timeout: run did not finish within %0d cycles", cycleLimit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

endmodule
